/* issue_stage.f */
+incdir+test
logic/issue_pkg.sv
logic/issue_queue.sv
logic/issue_pair_check.sv
logic/issue_operand_read.sv
logic/issue_stage.sv
test/issue_stage_tb.sv

/* logic/issue_operand_read.sv */
/*
 * register read addressing and the registered pair toward execute
 * read data must come back from the register file in the same cycle
 */

`timescale 1ns/1ps
`default_nettype none

module issue_operand_read
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           stall,
    input  decoded_instr_t head_instr_a,
    input  decoded_instr_t head_instr_b,
    input  logic           issue_a,
    input  logic           issue_b,
    output reg_addr_t      reg_read_addr_a0,
    output reg_addr_t      reg_read_addr_a1,
    output reg_addr_t      reg_read_addr_b0,
    output reg_addr_t      reg_read_addr_b1,
    input  word_t          reg_read_data_a0,
    input  word_t          reg_read_data_a1,
    input  word_t          reg_read_data_b0,
    input  word_t          reg_read_data_b1,
    output issued_instr_t  out_a,
    output issued_instr_t  out_b
);

    issued_instr_t next_a;
    issued_instr_t next_b;

    // four read ports with two per slot
    assign reg_read_addr_a0 = head_instr_a.src_a;
    assign reg_read_addr_a1 = head_instr_a.src_b;
    assign reg_read_addr_b0 = head_instr_b.src_a;
    assign reg_read_addr_b1 = head_instr_b.src_b;

    // slot a is all zero when held back
    always_comb
    begin
        next_a = '0;
        if (issue_a)
        begin
            next_a.valid = 1'b1;
            next_a.instr = head_instr_a;
            next_a.operand_a = reg_read_data_a0;
            next_a.operand_b = reg_read_data_a1;
        end
    end

    // slot b uses the same layout on the second port pair
    always_comb
    begin
        next_b = '0;
        if (issue_b)
        begin
            next_b.valid = 1'b1;
            next_b.instr = head_instr_b;
            next_b.operand_a = reg_read_data_b0;
            next_b.operand_b = reg_read_data_b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            out_a <= '0;
            out_b <= '0;
        end
        else if (flush)
        begin
            // flush overrides stall
            out_a <= '0;
            out_b <= '0;
        end
        else if (!stall)
        begin
            out_a <= next_a;
            out_b <= next_b;
        end
        // otherwise hold the pair for execute
    end

    // execute never sees a younger slot without the older one
    a_out_order: assert property (@(posedge clk) disable iff (!reset)
        out_b.valid |-> out_a.valid);

endmodule

`default_nettype wire

/* logic/issue_pair_check.sv */
/*
 * combinational pairing rules for the two oldest queue entries
 * register 0 gets no special treatment in the RAW check
 */

`timescale 1ns/1ps
`default_nettype none

module issue_pair_check
    import issue_pkg::*;
(
    input  logic           head_valid_a,
    input  logic           head_valid_b,
    input  decoded_instr_t head_instr_a,
    input  decoded_instr_t head_instr_b,
    output logic           issue_a,
    output logic           issue_b
);

    logic wait_delay_slot;
    logic branch_b;
    logic both_mem;
    logic both_mul_div;
    logic raw_reg;
    logic raw_hi_lo;
    logic block_b;

    // a branch in slot a must leave with its delay slot
    assign wait_delay_slot = head_instr_a.branch && !head_valid_b;

    // control transfer in slot b would need its own delay slot in the pair
    assign branch_b = head_instr_b.branch;

    // single memory port
    assign both_mem = head_instr_a.mem_access && head_instr_b.mem_access;

    // single multiply/divide unit
    assign both_mul_div = head_instr_a.mul_div && head_instr_b.mul_div;

    // general register read after write inside the pair
    assign raw_reg = head_instr_a.reg_write &&
                     ((head_instr_a.dest == head_instr_b.src_a) ||
                      (head_instr_a.dest == head_instr_b.src_b));

    // hi or lo written by slot a and read by slot b
    assign raw_hi_lo = (head_instr_a.hi_write && head_instr_b.hi_read) ||
                       (head_instr_a.lo_write && head_instr_b.lo_read);

    assign block_b = branch_b || both_mem || both_mul_div || raw_reg || raw_hi_lo;

    assign issue_a = head_valid_a && !wait_delay_slot;

    // slot b only goes together with slot a
    assign issue_b = issue_a && head_valid_b && !block_b;

endmodule

`default_nettype wire

/* logic/issue_pkg.sv */
/*
 * shared sizes and instruction types for the dual-issue stage
 * queue depth must stay a power of two so the indices wrap by overflow
 */

`default_nettype none

package issue_pkg;

    // queue geometry
    localparam int queue_depth = 8;
    // head and tail wrap naturally at this width
    localparam int queue_index_width = 3;

    // general register file
    localparam int reg_addr_width = 5;
    localparam int word_width = 32;

    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [word_width-1:0] word_t;
    typedef logic [queue_index_width-1:0] queue_index_t;

    // one instruction as it leaves decode
    typedef struct packed {
        // fetch address that also identifies the instruction
        word_t pc;
        // destination and source register numbers
        reg_addr_t dest;
        reg_addr_t src_a;
        reg_addr_t src_b;
        // writes dest in the general register file
        logic reg_write;
        // load or store
        logic mem_access;
        // hi/lo special registers
        logic hi_write;
        logic lo_write;
        logic hi_read;
        logic lo_read;
        // branch or jump that is always followed by a delay slot
        logic branch;
        // multiply or divide unit
        logic mul_div;
    } decoded_instr_t;

    // one slot of the pair sent toward execute
    typedef struct packed {
        logic valid;
        decoded_instr_t instr;
        // register file data for src_a and src_b
        word_t operand_a;
        word_t operand_b;
    } issued_instr_t;

endpackage

`default_nettype wire

/* logic/issue_queue.sv */
/*
 * eight-entry circular queue with two writes and two frees per cycle
 * overflow rejects the whole cycle so decode has to present it again
 */

`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           stall,
    input  logic           in_valid_a,
    input  logic           in_valid_b,
    input  decoded_instr_t in_instr_a,
    input  decoded_instr_t in_instr_b,
    input  logic           issue_a,
    input  logic           issue_b,
    output logic           overflow,
    output logic           head_valid_a,
    output logic           head_valid_b,
    output decoded_instr_t head_instr_a,
    output decoded_instr_t head_instr_b
);

    // entry storage
    decoded_instr_t entries [queue_depth];
    logic [queue_depth-1:0] valid;

    queue_index_t head;
    queue_index_t head_plus1;
    queue_index_t tail;
    queue_index_t tail_plus1;

    logic write_first;
    logic write_second;
    decoded_instr_t first_instr;

    // index arithmetic wraps at the index width
    assign head_plus1 = head + queue_index_t'(1);
    assign tail_plus1 = tail + queue_index_t'(1);

    // first written instruction is slot a if strobed, else the lone slot b
    assign first_instr = in_valid_a ? in_instr_a : in_instr_b;

    // overflow when the tail entry or the one after it is still occupied
    assign overflow = ((in_valid_a || in_valid_b) && valid[tail]) ||
                      (in_valid_a && in_valid_b && valid[tail_plus1]);

    // nothing lands during a flush or an overflow
    assign write_first = (in_valid_a || in_valid_b) && !overflow && !flush;
    assign write_second = in_valid_a && in_valid_b && !overflow && !flush;

    // oldest two entries toward the pairing stage
    assign head_valid_a = valid[head];
    assign head_valid_b = valid[head_plus1];
    assign head_instr_a = valid[head] ? entries[head] : '0;
    assign head_instr_b = valid[head_plus1] ? entries[head_plus1] : '0;

    always_ff @(posedge clk)
    begin
        if (write_first)
        begin
            entries[tail] <= first_instr;
        end
        if (write_second)
        begin
            entries[tail_plus1] <= in_instr_b;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid <= '0;
            head <= '0;
            tail <= '0;
        end
        else if (flush)
        begin
            // flush wins over stall and over any enqueue
            valid <= '0;
            head <= '0;
            tail <= '0;
        end
        else
        begin
            // head only moves when execute accepts the pair
            if (!stall)
            begin
                if (issue_a)
                begin
                    valid[head] <= 1'b0;
                end
                if (issue_b)
                begin
                    valid[head_plus1] <= 1'b0;
                end
                head <= head + queue_index_t'(issue_a) + queue_index_t'(issue_b);
            end
            // enqueue keeps going under stall
            // freed entries are valid, written ones were not, so no clash
            if (write_first)
            begin
                valid[tail] <= 1'b1;
            end
            if (write_second)
            begin
                valid[tail_plus1] <= 1'b1;
            end
            tail <= tail + queue_index_t'(write_first) + queue_index_t'(write_second);
        end
    end

    // tail reaches a live entry only when the queue is full
    a_no_overwrite: assert property (@(posedge clk) disable iff (!reset)
        valid[tail] |-> &valid);

    // pairing stage never issues the younger entry alone
    a_issue_order: assert property (@(posedge clk) disable iff (!reset)
        issue_b |-> issue_a);

endmodule

`default_nettype wire

/* logic/issue_stage.sv */
/*
 * dual-issue stage built from queue, pairing rules and operand read
 * earliest path from enqueue to out_a is one edge after the write
 */

`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import issue_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           stall,
    // decode side with single-cycle strobes
    input  logic           in_valid_a,
    input  logic           in_valid_b,
    input  decoded_instr_t in_instr_a,
    input  decoded_instr_t in_instr_b,
    output logic           overflow,
    // register file
    output reg_addr_t      reg_read_addr_a0,
    output reg_addr_t      reg_read_addr_a1,
    output reg_addr_t      reg_read_addr_b0,
    output reg_addr_t      reg_read_addr_b1,
    input  word_t          reg_read_data_a0,
    input  word_t          reg_read_data_a1,
    input  word_t          reg_read_data_b0,
    input  word_t          reg_read_data_b1,
    // toward execute
    output issued_instr_t  out_a,
    output issued_instr_t  out_b
);

    logic head_valid_a;
    logic head_valid_b;
    decoded_instr_t head_instr_a;
    decoded_instr_t head_instr_b;
    logic issue_a;
    logic issue_b;

    issue_queue queue_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .stall        (stall),
        .in_valid_a   (in_valid_a),
        .in_valid_b   (in_valid_b),
        .in_instr_a   (in_instr_a),
        .in_instr_b   (in_instr_b),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .overflow     (overflow),
        .head_valid_a (head_valid_a),
        .head_valid_b (head_valid_b),
        .head_instr_a (head_instr_a),
        .head_instr_b (head_instr_b)
    );

    // decisions return to the queue in the same cycle
    issue_pair_check pair_check_inst (
        .head_valid_a (head_valid_a),
        .head_valid_b (head_valid_b),
        .head_instr_a (head_instr_a),
        .head_instr_b (head_instr_b),
        .issue_a      (issue_a),
        .issue_b      (issue_b)
    );

    issue_operand_read operand_read_inst (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .stall            (stall),
        .head_instr_a     (head_instr_a),
        .head_instr_b     (head_instr_b),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .reg_read_addr_a0 (reg_read_addr_a0),
        .reg_read_addr_a1 (reg_read_addr_a1),
        .reg_read_addr_b0 (reg_read_addr_b0),
        .reg_read_addr_b1 (reg_read_addr_b1),
        .reg_read_data_a0 (reg_read_data_a0),
        .reg_read_data_a1 (reg_read_data_a1),
        .reg_read_data_b0 (reg_read_data_b0),
        .reg_read_data_b1 (reg_read_data_b1),
        .out_a            (out_a),
        .out_b            (out_b)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module issue_stage_tb \
    -f issue_stage.f -o issue_stage_sim

result=$(./obj_dir/issue_stage_sim)
echo "$result"

if echo "$result" | grep -qx "All checks passed"
then
    exit 0
fi
exit 1

/* test/issue_stage_checks.svh */
/*
 * compare tasks, register data model and pairing model for inclusion in the testbench module
 * the pairing model assumes the whole list is queued before the first issue
 */

`ifndef issue_stage_checks_svh
`define issue_stage_checks_svh

localparam word_t rf_seed = 32'h1078_fb3a;

// one round of xorshift32
function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// stateless register file contents
function automatic word_t reg_data(input reg_addr_t addr);
    return xorshift32(rf_seed ^ word_t'(addr));
endfunction

task automatic match_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Error: %s expected %h got %h", name, exp, got);
    end
endtask

task automatic match_instr(input string name, input decoded_instr_t got,
                           input decoded_instr_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Error: %s expected %h got %h", name, exp, got);
    end
endtask

// one output slot compared field by field
task automatic match_slot(input string name, input issued_instr_t got,
                          input issued_instr_t exp);
    match_bit({name, ".valid"}, got.valid, exp.valid);
    match_instr({name, ".instr"}, got.instr, exp.instr);
    check_count++;
    if ({got.operand_a, got.operand_b} !== {exp.operand_a, exp.operand_b})
    begin
        error_count++;
        $display("Error: %s.operands expected %h got %h", name,
                 {exp.operand_a, exp.operand_b}, {got.operand_a, got.operand_b});
    end
endtask

// reasons for holding back the younger of two entries
function automatic logic slot_b_blocked(input decoded_instr_t a, input decoded_instr_t b);
    return b.branch || (a.mem_access && b.mem_access) || (a.mul_div && b.mul_div) ||
           (a.reg_write && (a.dest == b.src_a || a.dest == b.src_b)) ||
           (a.hi_write && b.hi_read) || (a.lo_write && b.lo_read);
endfunction

// issued slot as execute should see it
function automatic issued_instr_t slot_expect(input decoded_instr_t d);
    issued_instr_t r;
    r = '0;
    r.valid = 1'b1;
    r.instr = d;
    r.operand_a = reg_data(d.src_a);
    r.operand_b = reg_data(d.src_b);
    return r;
endfunction

// walk the loaded list oldest first and cut it into groups
task automatic build_expected();
    int i;
    exp_a.delete();
    exp_b.delete();
    i = 0;
    while (i < loaded.size())
    begin
        exp_a.push_back(slot_expect(loaded[i]));
        if (i + 1 < loaded.size() && !slot_b_blocked(loaded[i], loaded[i + 1]))
        begin
            exp_b.push_back(slot_expect(loaded[i + 1]));
            i += 2;
        end
        else
        begin
            // lone slot a leaves slot b all zero
            exp_b.push_back('0);
            i += 1;
        end
    end
endtask

`endif

/* test/issue_stage_tb.sv */
/*
 * directed tests for the dual-issue stage with inputs changing 1 ns after the rising edge
 * each test loads under stall, releases it and compares issued groups in order
 */

`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb
    import issue_pkg::*;
();

    // 6 + 8 + 7 + 2 + 9 + 8 instructions over all tests
    localparam int total_instrs = 40;
    localparam int reset_cycles = 10;
    localparam int timeout_cycles = 40 * total_instrs + reset_cycles;

    // flag bit order is reg_write mem_access hi_write lo_write hi_read lo_read branch mul_div
    localparam logic [7:0] alu_flags = 8'b1000_0000;
    localparam logic [7:0] load_flags = 8'b1100_0000;
    localparam logic [7:0] store_flags = 8'b0100_0000;
    localparam logic [7:0] mul_flags = 8'b0011_0001;
    localparam logic [7:0] mthi_flags = 8'b0010_0000;
    localparam logic [7:0] mfhi_flags = 8'b1000_1000;
    localparam logic [7:0] mflo_flags = 8'b1000_0100;
    localparam logic [7:0] branch_flags = 8'b0000_0010;

    logic clk;
    logic reset;
    logic flush;
    logic stall;
    logic in_valid_a;
    logic in_valid_b;
    decoded_instr_t in_instr_a;
    decoded_instr_t in_instr_b;
    logic overflow;
    reg_addr_t reg_read_addr_a0;
    reg_addr_t reg_read_addr_a1;
    reg_addr_t reg_read_addr_b0;
    reg_addr_t reg_read_addr_b1;
    word_t reg_read_data_a0;
    word_t reg_read_data_a1;
    word_t reg_read_data_b0;
    word_t reg_read_data_b1;
    issued_instr_t out_a;
    issued_instr_t out_b;

    int error_count;
    int check_count;
    int cycle_count;
    // program of the running test and its expected groups
    decoded_instr_t loaded[$];
    issued_instr_t exp_a[$];
    issued_instr_t exp_b[$];

    `include "issue_stage_checks.svh"

    // register file answers in the same cycle
    assign reg_read_data_a0 = reg_data(reg_read_addr_a0);
    assign reg_read_data_a1 = reg_data(reg_read_addr_a1);
    assign reg_read_data_b0 = reg_data(reg_read_addr_b0);
    assign reg_read_data_b1 = reg_data(reg_read_addr_b1);

    issue_stage issue_stage_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("run stopped after %0d cycles with tests unfinished", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic decoded_instr_t make_instr(input int pc, input int dest, input int src_a,
                                                  input int src_b, input logic [7:0] flags);
        decoded_instr_t d;
        d.pc = word_t'(pc);
        d.dest = reg_addr_t'(dest);
        d.src_a = reg_addr_t'(src_a);
        d.src_b = reg_addr_t'(src_b);
        {d.reg_write, d.mem_access, d.hi_write, d.lo_write,
         d.hi_read, d.lo_read, d.branch, d.mul_div} = flags;
        return d;
    endfunction

    // strobe loaded[first..] two at a time and expect every strobe accepted
    task automatic strobe_range(input int first);
        int i;
        i = first;
        while (i < loaded.size())
        begin
            in_instr_a = loaded[i];
            in_valid_a = 1'b1;
            if (i + 1 < loaded.size())
            begin
                in_instr_b = loaded[i + 1];
                in_valid_b = 1'b1;
            end
            @(negedge clk);
            match_bit("overflow", overflow, 1'b0);
            @(posedge clk);
            #1;
            in_valid_a = 1'b0;
            in_valid_b = 1'b0;
            i += 2;
        end
    endtask

    task automatic reject_strobe(input decoded_instr_t d);
        in_instr_a = d;
        in_valid_a = 1'b1;
        @(negedge clk);
        match_bit("overflow", overflow, 1'b1);
        @(posedge clk);
        #1;
        in_valid_a = 1'b0;
    endtask

    // release stall and compare every valid output edge with a stall after group hold_at
    task automatic collect_groups(input int hold_at);
        int got;
        got = 0;
        stall = 1'b0;
        while (got < exp_a.size())
        begin
            @(posedge clk);
            #1;
            if (out_a.valid)
            begin
                match_slot("out_a", out_a, exp_a[got]);
                match_slot("out_b", out_b, exp_b[got]);
                got++;
                if (got == hold_at)
                begin
                    stall = 1'b1;
                    repeat (3)
                    begin
                        @(posedge clk);
                        #1;
                        match_slot("out_a", out_a, exp_a[got - 1]);
                        match_slot("out_b", out_b, exp_b[got - 1]);
                    end
                    stall = 1'b0;
                end
            end
        end
        // queue is empty so the next edge registers nothing
        @(posedge clk);
        #1;
        match_bit("out_a.valid", out_a.valid, 1'b0);
        match_bit("out_b.valid", out_b.valid, 1'b0);
    endtask

    task automatic independent_pairs();
        int k;
        stall = 1'b1;
        loaded.delete();
        for (k = 0; k < 3; k++)
        begin
            loaded.push_back(make_instr(32'h100 + 8 * k, k + 1, k + 10, k + 20, alu_flags));
            loaded.push_back(make_instr(32'h104 + 8 * k, k + 4, k + 13, k + 24, alu_flags));
        end
        strobe_range(0);
        build_expected();
        collect_groups(0);
    endtask

    task automatic hazard_splits();
        stall = 1'b1;
        loaded.delete();
        loaded.push_back(make_instr(32'h200, 5, 1, 2, alu_flags));
        loaded.push_back(make_instr(32'h204, 6, 5, 3, alu_flags));
        loaded.push_back(make_instr(32'h208, 7, 4, 4, alu_flags));
        loaded.push_back(make_instr(32'h20c, 0, 10, 11, mul_flags));
        loaded.push_back(make_instr(32'h210, 12, 0, 0, mflo_flags));
        loaded.push_back(make_instr(32'h214, 13, 15, 16, alu_flags));
        loaded.push_back(make_instr(32'h218, 0, 17, 0, mthi_flags));
        loaded.push_back(make_instr(32'h21c, 18, 0, 0, mfhi_flags));
        strobe_range(0);
        build_expected();
        collect_groups(0);
    endtask

    task automatic resource_splits();
        stall = 1'b1;
        loaded.delete();
        loaded.push_back(make_instr(32'h300, 1, 2, 0, load_flags));
        loaded.push_back(make_instr(32'h304, 0, 3, 4, store_flags));
        loaded.push_back(make_instr(32'h308, 5, 6, 7, alu_flags));
        loaded.push_back(make_instr(32'h30c, 0, 8, 9, mul_flags));
        loaded.push_back(make_instr(32'h310, 0, 10, 11, mul_flags));
        loaded.push_back(make_instr(32'h314, 0, 12, 13, branch_flags));
        loaded.push_back(make_instr(32'h318, 14, 15, 16, alu_flags));
        strobe_range(0);
        build_expected();
        collect_groups(0);
    endtask

    // branch waits at the head until its delay slot arrives
    task automatic branch_delay_slot();
        stall = 1'b1;
        loaded.delete();
        loaded.push_back(make_instr(32'h400, 0, 1, 2, branch_flags));
        strobe_range(0);
        stall = 1'b0;
        repeat (6)
        begin
            @(posedge clk);
            #1;
            match_bit("out_a.valid", out_a.valid, 1'b0);
        end
        loaded.push_back(make_instr(32'h404, 3, 4, 5, alu_flags));
        strobe_range(1);
        build_expected();
        collect_groups(0);
    endtask

    task automatic queue_overflow();
        int k;
        stall = 1'b1;
        loaded.delete();
        for (k = 0; k < queue_depth; k++)
        begin
            loaded.push_back(make_instr(32'h500 + 4 * k, 20 + k, k + 1, k + 2, alu_flags));
        end
        strobe_range(0);
        // ninth instruction finds the queue full
        reject_strobe(make_instr(32'h5f0, 30, 1, 1, alu_flags));
        build_expected();
        collect_groups(1);
    endtask

    task automatic flush_and_reload();
        int k;
        stall = 1'b1;
        loaded.delete();
        for (k = 0; k < 4; k++)
        begin
            loaded.push_back(make_instr(32'h600 + 4 * k, 10 + k, k + 1, k + 2, alu_flags));
        end
        strobe_range(0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        stall = 1'b0;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            match_bit("out_a.valid", out_a.valid, 1'b0);
            match_bit("out_b.valid", out_b.valid, 1'b0);
        end
        stall = 1'b1;
        loaded.delete();
        for (k = 0; k < 4; k++)
        begin
            loaded.push_back(make_instr(32'h700 + 4 * k, 20 + k, k + 3, k + 5, alu_flags));
        end
        strobe_range(0);
        build_expected();
        collect_groups(0);
    endtask

    initial
    begin
        reset = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        in_valid_a = 1'b0;
        in_valid_b = 1'b0;
        in_instr_a = '0;
        in_instr_b = '0;
        error_count = 0;
        check_count = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        match_bit("out_a.valid", out_a.valid, 1'b0);
        match_bit("out_b.valid", out_b.valid, 1'b0);
        independent_pairs();
        hazard_splits();
        resource_splits();
        branch_delay_slot();
        queue_overflow();
        flush_and_reload();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
